// File: verilog/word_types_pkg.sv
package word_types_pkg;

    // data widths of the execute stage
    // operands, quotient, remainder and result all share one word
    typedef logic [31:0] word_t;            // 32-bit data word

    // full multiplier output
    // low half feeds mul, high half feeds mulh/mulhu
    typedef logic [63:0] dword_t;           // 64-bit product

endpackage

// File: verilog/muldiv_op_pkg.sv
package muldiv_op_pkg;

    // op codes handled by the mul/div part of EX
    typedef enum logic [2:0] {
        op_mul   = 3'd0,                    // low word of product
        op_mulh  = 3'd1,                    // high word, signed x signed
        op_mulhu = 3'd2,                    // high word, unsigned x unsigned
        op_div   = 3'd3,                    // signed quotient
        op_divu  = 3'd4,                    // unsigned quotient
        op_rem   = 3'd5,                    // signed remainder
        op_remu  = 3'd6                     // unsigned remainder
    } muldiv_op_t;

    // which value MEM puts on the result bus
    typedef enum logic [1:0] {
        sel_prod_lo = 2'd0,                 // prod[31:0]
        sel_prod_hi = 2'd1,                 // prod[63:32]
        sel_quo     = 2'd2,                 // divider quotient
        sel_rem     = 2'd3                  // divider remainder
    } res_sel_t;

endpackage

// File: verilog/id_ex_reg.sv
`timescale 1ns/1ps
module id_ex_reg (
    input  logic                     clk_div,
    input  logic                     rstn,
    input  logic                     issue,     // one-cycle issue strobe
    input  muldiv_op_pkg::muldiv_op_t issue_op,
    input  word_types_pkg::word_t    issue_a,
    input  word_types_pkg::word_t    issue_b,
    input  logic                     hold,      // divider stall
    output logic                     ex_valid,
    output muldiv_op_pkg::muldiv_op_t ex_op,
    output word_types_pkg::word_t    ex_a,
    output word_types_pkg::word_t    ex_b
);

    // valid bit, the only control state here
    always_ff @(posedge clk_div or negedge rstn) begin
        if (!rstn) begin
            ex_valid <= 1'b0;
        end else if (!hold) begin
            ex_valid <= issue;              // takes the strobe as is
        end
    end

    // op and operands, frozen while the divider works
    // keeps div_en, div_signed and div_x/div_y steady for all 33 EX cycles
    always_ff @(posedge clk_div) begin
        if (!hold) begin
            ex_op <= issue_op;
            ex_a  <= issue_a;               // dividend / multiplicand
            ex_b  <= issue_b;               // divisor / multiplier
        end
    end

endmodule

// File: verilog/muldiv_decode.sv
`timescale 1ns/1ps
module muldiv_decode (
    input  logic                      ex_valid,
    input  muldiv_op_pkg::muldiv_op_t ex_op,
    output logic                      div_en,        // divider runs this op
    output logic                      div_signed,    // div/rem
    output logic                      mul_signed_a,  // sign-extend a
    output logic                      mul_signed_b,  // sign-extend b
    output muldiv_op_pkg::res_sel_t   sel            // MEM result pick
);

    logic is_div;                                    // op belongs to the divider

    always_comb begin
        is_div       = 1'b0;
        div_signed   = 1'b0;
        mul_signed_a = 1'b0;
        mul_signed_b = 1'b0;
        sel          = muldiv_op_pkg::sel_prod_lo;
        case (ex_op)
            muldiv_op_pkg::op_mul: begin
                sel = muldiv_op_pkg::sel_prod_lo;    // low word same either way
            end
            muldiv_op_pkg::op_mulh: begin
                mul_signed_a = 1'b1;
                mul_signed_b = 1'b1;
                sel          = muldiv_op_pkg::sel_prod_hi;
            end
            muldiv_op_pkg::op_mulhu: begin
                sel = muldiv_op_pkg::sel_prod_hi;    // both zero-extended
            end
            muldiv_op_pkg::op_div: begin
                is_div     = 1'b1;
                div_signed = 1'b1;
                sel        = muldiv_op_pkg::sel_quo;
            end
            muldiv_op_pkg::op_divu: begin
                is_div = 1'b1;
                sel    = muldiv_op_pkg::sel_quo;
            end
            muldiv_op_pkg::op_rem: begin
                is_div     = 1'b1;
                div_signed = 1'b1;
                sel        = muldiv_op_pkg::sel_rem;
            end
            muldiv_op_pkg::op_remu: begin
                is_div = 1'b1;
                sel    = muldiv_op_pkg::sel_rem;
            end
            default: begin
                is_div = 1'b0;                       // unused code, treat as mul
            end
        endcase
    end

    assign div_en = ex_valid & is_div;               // no divide without a valid op

endmodule

// File: verilog/div_iter.sv
`timescale 1ns/1ps
module div_iter (
    input  logic                  clk_div,
    input  logic                  rstn,
    input  logic                  div_en,       // held high for 33 EX cycles
    input  logic                  div_signed,   // held with div_en
    input  word_types_pkg::word_t div_x,        // dividend
    input  word_types_pkg::word_t div_y,        // divisor
    output logic                  stall_div,    // to ID/EX hold and busy
    output word_types_pkg::word_t div_quo,      // MEM-timed quotient
    output word_types_pkg::word_t div_rem       // MEM-timed remainder
);

    word_types_pkg::word_t x_abs;               // |dividend|
    word_types_pkg::word_t y_abs;               // |divisor|, also the subtrahend

    // one-hot step counter, shifted left each step
    // bit 32 set means idle or finished
    logic [32:0] loop_cnt;

    // upper half builds the remainder, lower half shifts the dividend out
    // and the quotient bits in
    logic [63:0] dvd_rmd;

    logic signed_buf;                           // signedness for MEM fixup
    logic x_sign_buf;                           // dividend sign for MEM
    logic y_sign_buf;                           // divisor sign for MEM

    word_types_pkg::word_t quo_raw;             // unsigned quotient
    word_types_pkg::word_t rem_raw;             // unsigned remainder

    // stall for the first 32 EX cycles, released in the 33rd
    assign stall_div = div_en & ~loop_cnt[31];

    // two's complement magnitudes, only for signed ops
    assign x_abs = (div_signed && div_x[31]) ? (~div_x + 32'd1) : div_x;
    assign y_abs = (div_signed && div_y[31]) ? (~div_y + 32'd1) : div_y;

    // sign info follows the op one cycle late, into MEM
    always_ff @(posedge clk_div) begin
        signed_buf <= div_signed;
        x_sign_buf <= div_x[31];
        y_sign_buf <= div_y[31];
    end

    always_ff @(posedge clk_div or negedge rstn) begin
        if (!rstn) begin
            loop_cnt <= {1'b1, 32'd0};          // idle
            dvd_rmd  <= 64'd0;
        end else if (loop_cnt[32] && !div_en) begin
            loop_cnt <= {1'b1, 32'd0};          // stay idle, no divide in EX
            dvd_rmd  <= 64'd0;
        end else if (loop_cnt[32] && div_en) begin
            loop_cnt <= 33'd1;                  // prepare, first step next
            dvd_rmd  <= {32'd0, x_abs};
        end else if (dvd_rmd[62:31] < y_abs) begin
            loop_cnt <= loop_cnt << 1;          // quotient bit 0
            dvd_rmd  <= {dvd_rmd[62:0], 1'b0};
        end else begin
            loop_cnt <= loop_cnt << 1;          // quotient bit 1, subtract
            dvd_rmd  <= {dvd_rmd[62:31] - y_abs, dvd_rmd[30:0], 1'b1};
        end
    end

    assign quo_raw = dvd_rmd[31:0];
    assign rem_raw = dvd_rmd[63:32];

    // sign fixup
    //  x  y | q  r
    //  +  + | +  +
    //  +  - | -  +
    //  -  + | -  -
    //  -  - | +  -
    always_comb begin
        div_quo = quo_raw;
        div_rem = rem_raw;
        if (signed_buf) begin
            if (x_sign_buf != y_sign_buf) begin
                div_quo = ~(quo_raw - 32'd1);   // negate
            end
            if (x_sign_buf) begin
                div_rem = ~(rem_raw - 32'd1);   // follows dividend
            end
        end
    end

endmodule

// File: verilog/mul_unit.sv
`timescale 1ns/1ps
module mul_unit (
    input  logic                   signed_a,   // sign-extend a, else zero
    input  logic                   signed_b,   // sign-extend b, else zero
    input  word_types_pkg::word_t  a,
    input  word_types_pkg::word_t  b,
    output word_types_pkg::dword_t prod        // full 64-bit product
);

    logic signed [32:0] a_ext;                 // 33 bits covers both cases
    logic signed [32:0] b_ext;
    logic signed [65:0] full;                  // top two bits are sign copies

    // extra top bit is the sign or zero as chosen
    assign a_ext = {signed_a & a[31], a};
    assign b_ext = {signed_b & b[31], b};

    // one signed multiply serves signed and unsigned ops
    assign full = a_ext * b_ext;

    assign prod = full[63:0];                  // drop the redundant bits

endmodule

// File: verilog/ex_mem_stage.sv
`timescale 1ns/1ps
module ex_mem_stage (
    input  logic                    clk_div,
    input  logic                    rstn,
    input  logic                    stall,      // divider still working
    input  logic                    ex_valid,
    input  muldiv_op_pkg::res_sel_t sel,
    input  word_types_pkg::dword_t  prod,
    input  word_types_pkg::word_t   div_quo,    // already MEM-timed
    input  word_types_pkg::word_t   div_rem,    // already MEM-timed
    output logic                    res_valid,
    output word_types_pkg::word_t   res_data
);

    muldiv_op_pkg::res_sel_t mem_sel;           // selector in MEM
    word_types_pkg::dword_t  mem_prod;          // product in MEM

    // a stalled EX cycle passes a bubble, so each op pulses once
    always_ff @(posedge clk_div or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= ex_valid & ~stall;
        end
    end

    // payload moves only with the op
    always_ff @(posedge clk_div) begin
        if (!stall) begin
            mem_sel  <= sel;
            mem_prod <= prod;
        end
    end

    // result mux
    always_comb begin
        case (mem_sel)
            muldiv_op_pkg::sel_prod_lo: res_data = mem_prod[31:0];
            muldiv_op_pkg::sel_prod_hi: res_data = mem_prod[63:32];
            muldiv_op_pkg::sel_quo:     res_data = div_quo;
            muldiv_op_pkg::sel_rem:     res_data = div_rem;
            default:                    res_data = mem_prod[31:0];
        endcase
    end

endmodule

// File: verilog/muldiv_top.sv
`timescale 1ns/1ps
module muldiv_top (
    input  logic                      clk_div,
    input  logic                      rstn,
    input  logic                      issue,
    input  muldiv_op_pkg::muldiv_op_t issue_op,
    input  word_types_pkg::word_t     issue_a,
    input  word_types_pkg::word_t     issue_b,
    output logic                      busy,       // issue ignored while high
    output logic                      res_valid,
    output word_types_pkg::word_t     res_data
);

    logic                      ex_valid;
    muldiv_op_pkg::muldiv_op_t ex_op;
    word_types_pkg::word_t     ex_a;
    word_types_pkg::word_t     ex_b;
    logic                      div_en;
    logic                      div_signed;
    logic                      mul_signed_a;
    logic                      mul_signed_b;
    muldiv_op_pkg::res_sel_t   sel;
    logic                      stall_div;         // hold, stall and busy
    word_types_pkg::word_t     div_quo;
    word_types_pkg::word_t     div_rem;
    word_types_pkg::dword_t    prod;

    assign busy = stall_div;

    id_ex_reg u_id_ex (
        .clk_div  (clk_div),
        .rstn     (rstn),
        .issue    (issue),
        .issue_op (issue_op),
        .issue_a  (issue_a),
        .issue_b  (issue_b),
        .hold     (stall_div),
        .ex_valid (ex_valid),
        .ex_op    (ex_op),
        .ex_a     (ex_a),
        .ex_b     (ex_b)
    );

    muldiv_decode u_decode (
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .div_en       (div_en),
        .div_signed   (div_signed),
        .mul_signed_a (mul_signed_a),
        .mul_signed_b (mul_signed_b),
        .sel          (sel)
    );

    div_iter u_div (
        .clk_div    (clk_div),
        .rstn       (rstn),
        .div_en     (div_en),
        .div_signed (div_signed),
        .div_x      (ex_a),
        .div_y      (ex_b),
        .stall_div  (stall_div),
        .div_quo    (div_quo),
        .div_rem    (div_rem)
    );

    mul_unit u_mul (
        .signed_a (mul_signed_a),
        .signed_b (mul_signed_b),
        .a        (ex_a),
        .b        (ex_b),
        .prod     (prod)
    );

    ex_mem_stage u_ex_mem (
        .clk_div   (clk_div),
        .rstn      (rstn),
        .stall     (stall_div),
        .ex_valid  (ex_valid),
        .sel       (sel),
        .prod      (prod),
        .div_quo   (div_quo),
        .div_rem   (div_rem),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

endmodule

// File: verification/tb_muldiv_vectors.svh
`ifndef TB_MULDIV_VECTORS_SVH
`define TB_MULDIV_VECTORS_SVH

task automatic load_table();
    // op, a, b, expected res_data, back-to-back, pulse issue while busy
    add_vec(muldiv_op_pkg::op_mul,   32'h0000_0007, 32'h0000_0006, 32'h0000_002a, 0, 0);
    add_vec(muldiv_op_pkg::op_mul,   32'hffff_fffd, 32'h0000_0005, 32'hffff_fff1, 0, 0);
    add_vec(muldiv_op_pkg::op_mulh,  32'hffff_fffd, 32'h0000_0005, 32'hffff_ffff, 0, 0);
    add_vec(muldiv_op_pkg::op_mulhu, 32'hffff_fffd, 32'h0000_0005, 32'h0000_0004, 0, 0);
    add_vec(muldiv_op_pkg::op_mulh,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 0, 0);
    add_vec(muldiv_op_pkg::op_mulhu, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe, 1, 0);
    add_vec(muldiv_op_pkg::op_mulhu, 32'h0001_0000, 32'h0001_0000, 32'h0000_0001, 1, 0);
    // unsigned divide, small dividend included
    add_vec(muldiv_op_pkg::op_divu,  32'h0000_0064, 32'h0000_0007, 32'h0000_000e, 0, 0);
    add_vec(muldiv_op_pkg::op_remu,  32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 0, 0);
    add_vec(muldiv_op_pkg::op_divu,  32'h0000_0005, 32'h0000_0009, 32'h0000_0000, 0, 0);
    add_vec(muldiv_op_pkg::op_remu,  32'h0000_0005, 32'h0000_0009, 32'h0000_0005, 0, 0);
    add_vec(muldiv_op_pkg::op_divu,  32'hffff_ffff, 32'h0000_0010, 32'h0fff_ffff, 0, 0);
    add_vec(muldiv_op_pkg::op_remu,  32'hffff_ffff, 32'h0000_0010, 32'h0000_000f, 0, 0);
    // signed divide, all four sign pairs
    add_vec(muldiv_op_pkg::op_div,   32'h0000_0007, 32'h0000_0002, 32'h0000_0003, 0, 0);
    add_vec(muldiv_op_pkg::op_rem,   32'h0000_0007, 32'h0000_0002, 32'h0000_0001, 0, 0);
    add_vec(muldiv_op_pkg::op_div,   32'h0000_0007, 32'hffff_fffe, 32'hffff_fffd, 0, 0);
    add_vec(muldiv_op_pkg::op_rem,   32'h0000_0007, 32'hffff_fffe, 32'h0000_0001, 0, 0);
    add_vec(muldiv_op_pkg::op_div,   32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd, 0, 0);
    add_vec(muldiv_op_pkg::op_rem,   32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff, 0, 0);
    add_vec(muldiv_op_pkg::op_div,   32'hffff_fff9, 32'hffff_fffe, 32'h0000_0003, 0, 0);
    add_vec(muldiv_op_pkg::op_rem,   32'hffff_fff9, 32'hffff_fffe, 32'hffff_ffff, 0, 0);
    add_vec(muldiv_op_pkg::op_div,   32'h8000_0000, 32'hffff_ffff, 32'h8000_0000, 0, 0);
    add_vec(muldiv_op_pkg::op_rem,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 0, 0);
    // divide by zero
    add_vec(muldiv_op_pkg::op_divu,  32'h0000_1234, 32'h0000_0000, 32'hffff_ffff, 0, 0);
    add_vec(muldiv_op_pkg::op_remu,  32'h0000_1234, 32'h0000_0000, 32'h0000_1234, 0, 0);
    add_vec(muldiv_op_pkg::op_div,   32'h0000_0005, 32'h0000_0000, 32'hffff_ffff, 0, 0);
    add_vec(muldiv_op_pkg::op_rem,   32'h0000_0005, 32'h0000_0000, 32'h0000_0005, 0, 0);
    add_vec(muldiv_op_pkg::op_div,   32'hffff_fffb, 32'h0000_0000, 32'h0000_0001, 0, 0);
    add_vec(muldiv_op_pkg::op_rem,   32'hffff_fffb, 32'h0000_0000, 32'hffff_fffb, 0, 0);
    // back to back, div on busy fall, then mul right after div
    add_vec(muldiv_op_pkg::op_div,   32'h0000_03e8, 32'h0000_000a, 32'h0000_0064, 0, 1);
    add_vec(muldiv_op_pkg::op_div,   32'hffff_ff9c, 32'h0000_0007, 32'hffff_fff2, 1, 1);
    add_vec(muldiv_op_pkg::op_mul,   32'h0000_0003, 32'h0000_0004, 32'h0000_000c, 1, 0);
    add_vec(muldiv_op_pkg::op_remu,  32'h0000_0064, 32'h0000_0007, 32'h0000_0002, 1, 0);
endtask

`endif

// File: verification/tb_muldiv.sv
`timescale 1ns/1ps
module tb_muldiv;

    localparam int rand_count = 24;                  // extra random ops

    logic                      clk_div;
    logic                      rstn;
    logic                      issue;
    muldiv_op_pkg::muldiv_op_t issue_op;
    word_types_pkg::word_t     issue_a;
    word_types_pkg::word_t     issue_b;
    logic                      busy;
    logic                      res_valid;
    word_types_pkg::word_t     res_data;

    int     cyc = 0;                                 // posedge count
    int     div_start = -100;                        // cycle of last divide issue
    int     last_due = 0;                            // cycle the last result is due
    logic   loaded = 1'b0;                           // table ready, watchdog may start
    integer seed = 32'h4548_3338;

    muldiv_op_pkg::muldiv_op_t tab_op[$];            // vector table
    word_types_pkg::word_t     tab_a[$];
    word_types_pkg::word_t     tab_b[$];
    word_types_pkg::word_t     tab_exp[$];
    bit                        tab_b2b[$];
    bit                        tab_poke[$];
    int                        due_q[$];             // in-flight results, issue order
    word_types_pkg::word_t     exp_q[$];

    muldiv_top dut (
        .clk_div   (clk_div),
        .rstn      (rstn),
        .issue     (issue),
        .issue_op  (issue_op),
        .issue_a   (issue_a),
        .issue_b   (issue_b),
        .busy      (busy),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    task automatic add_vec(input muldiv_op_pkg::muldiv_op_t op, input word_types_pkg::word_t a,
                           input word_types_pkg::word_t b, input word_types_pkg::word_t exp,
                           input bit b2b, input bit poke);
        tab_op.push_back(op);
        tab_a.push_back(a);
        tab_b.push_back(b);
        tab_exp.push_back(exp);
        tab_b2b.push_back(b2b);
        tab_poke.push_back(poke);
    endtask

    `include "tb_muldiv_vectors.svh"

    task automatic check_word(input string name, input word_types_pkg::word_t exp,
                              input word_types_pkg::word_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            $display("FAIL: see errors above");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    function automatic bit takes_divider(input muldiv_op_pkg::muldiv_op_t op);
        return op inside {muldiv_op_pkg::op_div, muldiv_op_pkg::op_divu,
                          muldiv_op_pkg::op_rem, muldiv_op_pkg::op_remu};
    endfunction

    // result from the op rules, div by zero included
    function automatic word_types_pkg::word_t ref_result(input muldiv_op_pkg::muldiv_op_t op,
            input word_types_pkg::word_t a, input word_types_pkg::word_t b);
        longint                sp;                   // signed product
        longint unsigned       up;                   // unsigned product
        word_types_pkg::word_t ma;                   // magnitudes
        word_types_pkg::word_t mb;
        word_types_pkg::word_t q;
        word_types_pkg::word_t r;
        bit                    sgn;
        sp  = longint'($signed(a)) * longint'($signed(b));
        up  = {32'd0, a} * {32'd0, b};
        sgn = (op == muldiv_op_pkg::op_div) || (op == muldiv_op_pkg::op_rem);
        ma  = (sgn && a[31]) ? -a : a;
        mb  = (sgn && b[31]) ? -b : b;
        q   = (mb == 32'd0) ? 32'hffff_ffff : ma / mb;
        r   = (mb == 32'd0) ? ma : ma % mb;
        if (sgn && (a[31] != b[31]))
            q = -q;                                  // quotient sign from both
        if (sgn && a[31])
            r = -r;                                  // remainder follows dividend
        case (op)
            muldiv_op_pkg::op_mul:                          return sp[31:0];
            muldiv_op_pkg::op_mulh:                         return sp[63:32];
            muldiv_op_pkg::op_mulhu:                        return up[63:32];
            muldiv_op_pkg::op_div, muldiv_op_pkg::op_divu:  return q;
            default:                                        return r;
        endcase
    endfunction

    // issue one op when busy is low, called at a falling edge
    task automatic send_op(input muldiv_op_pkg::muldiv_op_t op, input word_types_pkg::word_t a,
                           input word_types_pkg::word_t b, input word_types_pkg::word_t exp,
                           input bit b2b, input bit poke);
        int due;
        while (busy === 1'b1 || (!b2b && cyc < last_due))
            @(negedge clk_div);
        issue    = 1'b1;
        issue_op = op;
        issue_a  = a;
        issue_b  = b;
        due = cyc + (takes_divider(op) ? 34 : 2);    // seen at this falling edge
        if (takes_divider(op))
            div_start = cyc;
        due_q.push_back(due);
        exp_q.push_back(exp);
        last_due = due;
        @(negedge clk_div);
        issue = 1'b0;
        if (poke) begin
            repeat (3) @(negedge clk_div);
            issue = 1'b1;                            // divider busy, must be dropped
            @(negedge clk_div);
            issue = 1'b0;
        end
    endtask

    initial begin
        clk_div = 1'b0;
        forever #20 clk_div = ~clk_div;
    end

    always @(posedge clk_div)
        cyc <= cyc + 1;

    // busy, res_valid and res_data every falling edge
    initial begin : monitor
        logic exp_busy;
        logic exp_valid;
        wait (rstn === 1'b1);
        forever begin
            @(negedge clk_div);
            exp_busy  = (cyc > div_start) && (cyc <= div_start + 32);
            exp_valid = (due_q.size() > 0) && (cyc == due_q[0]);
            check_bit("busy", exp_busy, busy);
            check_bit("res_valid", exp_valid, res_valid);
            if (exp_valid) begin
                check_word("res_data", exp_q[0], res_data);
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        longint limit;
        wait (loaded === 1'b1);
        limit = (tab_op.size() + rand_count) * 40 + 3;  // cycles
        #(limit * 40);
        $display("Timeout: no res_valid within %0d cycles, run stopped", limit);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    initial begin : main
        muldiv_op_pkg::muldiv_op_t r_op;
        word_types_pkg::word_t     r_a;
        word_types_pkg::word_t     r_b;
        logic [2:0]                r_code;
        int                        r_kind;
        bit                        r_b2b;
        int                        i;
        rstn     = 1'b0;
        issue    = 1'b0;
        issue_op = muldiv_op_pkg::op_mul;
        issue_a  = '0;
        issue_b  = '0;
        load_table();
        loaded = 1'b1;
        repeat (3) @(posedge clk_div);
        @(negedge clk_div);
        check_bit("busy", 1'b0, busy);               // idle out of reset
        check_bit("res_valid", 1'b0, res_valid);
        rstn = 1'b1;
        for (i = 0; i < tab_op.size(); i++)
            send_op(tab_op[i], tab_a[i], tab_b[i], tab_exp[i], tab_b2b[i], tab_poke[i]);
        for (i = 0; i < rand_count; i++) begin
            r_code = $unsigned($random(seed)) % 7;
            r_op   = muldiv_op_pkg::muldiv_op_t'(r_code);
            r_a    = $random(seed);
            r_b    = $random(seed);
            r_kind = $unsigned($random(seed)) % 8;
            r_b2b  = $random(seed);
            if (r_kind == 0)
                r_b = 32'd0;                         // divide by zero
            else if (r_kind == 1)
                r_b = r_b >> 24;                     // small divisor
            else if (r_kind == 2)
                r_b = 32'hffff_ffff;
            send_op(r_op, r_a, r_b, ref_result(r_op, r_a, r_b), r_b2b, 1'b0);
        end
        while (cyc < last_due + 4)                   // watch for stray pulses
            @(negedge clk_div);
        @(posedge clk_div);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: list.f
+incdir+verification
verilog/word_types_pkg.sv
verilog/muldiv_op_pkg.sv
verilog/id_ex_reg.sv
verilog/muldiv_decode.sv
verilog/div_iter.sv
verilog/mul_unit.sv
verilog/ex_mem_stage.sv
verilog/muldiv_top.sv
verification/tb_muldiv.sv
